//--- verif/mac_golden.txt
// Seven hex words per record: op a b c d e f. op 0 end of test a, 1 table load slot field data,
// 2 write addr data, 3 read addr expected, 4 run mode r13 r14 r15 pc result, 5 overlapped read
0001 0000 0000 0100 0000 0000 0000
0001 0000 0001 0140 0000 0000 0000
0001 0000 0002 0140 0000 0000 0000
0001 0000 0003 0160 0000 0000 0000
0001 0000 0004 0001 0000 0000 0000
0001 0001 0000 0020 0000 0000 0000
0001 0001 0001 0026 0000 0000 0000
0001 0001 0002 0030 0000 0000 0000
0001 0001 0003 0038 0000 0000 0000
0001 0001 0004 0002 0000 0000 0000
0002 0020 1234 0000 0000 0000 0000
0002 0022 ABCD 0000 0000 0000 0000
0002 0024 0F0F 0000 0000 0000 0000
0002 0040 0102 0000 0000 0000 0000
0002 0042 0304 0000 0000 0000 0000
0002 0044 F00D 0000 0000 0000 0000
0002 0046 CAFE 0000 0000 0000 0000
0002 0048 1111 0000 0000 0000 0000
0002 0062 BEEF 0000 0000 0000 0000
0003 0020 1234 0000 0000 0000 0000
0003 0024 0F0F 0000 0000 0000 0000
0003 0044 F00D 0000 0000 0000 0000
0003 0062 BEEF 0000 0000 0000 0000
0000 0001 0000 0000 0000 0000 0000
0004 0000 0040 004A 0060 0110 659D
0003 0060 659D 0000 0000 0000 0000
0000 0002 0000 0000 0000 0000 0000
0004 0000 0040 004A 0062 0200 0000
0003 0062 BEEF 0000 0000 0000 0000
0000 0003 0000 0000 0000 0000 0000
0002 0070 5FA9 0000 0000 0000 0000
0004 0001 0000 0022 0070 0000 0002
0000 0004 0000 0000 0000 0000 0000
0002 0072 5FA8 0000 0000 0000 0000
0004 0001 0000 0022 0072 0000 0000
0000 0005 0000 0000 0000 0000 0000
0005 0040 0102 0000 0000 0000 0000
0005 0042 0304 0000 0000 0000 0000
0005 0048 1111 0000 0000 0000 0000
0005 0020 1234 0000 0000 0000 0000
0005 0070 5FA9 0000 0000 0000 0000
0005 0062 BEEF 0000 0000 0000 0000
0004 0000 0040 004A 0064 0110 659D
0003 0064 659D 0000 0000 0000 0000
0000 0006 0000 0000 0000 0000 0000
000F 0000 0000 0000 0000 0000 0000

//--- files.f
+incdir+logic
logic/mem_pkg.sv
logic/mac_pkg.sv
logic/bus_ifs.sv
logic/data_ram.sv
logic/mem_arbiter.sv
logic/spm_table.sv
logic/mac_engine.sv
logic/mac_control.sv
logic/mac_unit_top.sv
verif/tb_clock.sv
verif/mac_unit_tb.sv

//--- verif/mac_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "mac_consts.svh"

module mac_unit_tb;
  import mem_pkg::*;
  import mac_pkg::*;

  localparam int GOLD_WORDS = 7 * 48;
  localparam int WAIT_LIMIT = 400;
  localparam int SLOT_W     = $clog2(`SPM_SLOTS);

  logic              clk;
  logic              reset;
  logic              start;
  mac_mode_t         mode;
  addr_t             r13;
  addr_t             r14;
  addr_t             r15;
  addr_t             pc;
  logic              busy;
  word_t             result;
  logic              result_valid;
  logic              host_valid;
  logic              host_ready;
  logic              host_we;
  addr_t             host_addr;
  word_t             host_wdata;
  logic              host_rvalid;
  word_t             host_rdata;
  logic              spm_load_valid;
  logic [SLOT_W-1:0] spm_load_slot;
  spm_field_t        spm_load_field;
  word_t             spm_load_data;

  // Golden records of seven words each
  word_t gold [GOLD_WORDS];
  // Host reads that overlap the next operation
  addr_t bg_addr [$];
  word_t bg_data [$];

  int errors;
  int test_errors;
  int checks;
  int tests_run;
  int tests_failed;

  tb_clock u_clock (.clk(clk));

  mac_unit_top dut (
    .clk(clk), .reset(reset), .start(start), .mode(mode),
    .r13(r13), .r14(r14), .r15(r15), .pc(pc),
    .busy(busy), .result(result), .result_valid(result_valid),
    .host_valid(host_valid), .host_ready(host_ready), .host_we(host_we),
    .host_addr(host_addr), .host_wdata(host_wdata),
    .host_rvalid(host_rvalid), .host_rdata(host_rdata),
    .spm_load_valid(spm_load_valid), .spm_load_slot(spm_load_slot),
    .spm_load_field(spm_load_field), .spm_load_data(spm_load_data)
  );

  task automatic abort_on_timeout(input string what);
    $display("Timeout: %s did not arrive within %0d cycles", what, WAIT_LIMIT);
    $display("FAIL: see errors above");
    $finish;
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  // One host transfer that returns the read data
  task automatic host_access(input logic we, input addr_t addr, input word_t wdata,
                             output word_t rdata);
    int n;
    @(negedge clk);
    host_valid = 1'b1;
    host_we    = we;
    host_addr  = addr;
    host_wdata = wdata;
    n = 0;
    // Ready settles shortly after the falling edge
    #1;
    while (!host_ready)
    begin
      n++;
      if (n > WAIT_LIMIT)
        abort_on_timeout("host_ready");
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    host_valid = 1'b0;
    rdata = '0;
    n = 0;
    while (!we && !host_rvalid)
    begin
      n++;
      if (n > WAIT_LIMIT)
        abort_on_timeout("host_rvalid");
      @(negedge clk);
    end
    if (!we)
      rdata = host_rdata;
  endtask

  task automatic run_operation(input mac_mode_t op_mode, input addr_t a13, input addr_t a14,
                               input addr_t a15, input addr_t op_pc, output word_t res);
    int n;
    n = 0;
    @(negedge clk);
    while (busy)
    begin
      n++;
      if (n > WAIT_LIMIT)
        abort_on_timeout("busy low before start");
      @(negedge clk);
    end
    mode  = op_mode;
    r13   = a13;
    r14   = a14;
    r15   = a15;
    pc    = op_pc;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    n = 0;
    while (!result_valid)
    begin
      n++;
      if (n > WAIT_LIMIT)
        abort_on_timeout("result_valid");
      @(negedge clk);
    end
    res = result;
    @(negedge clk);
    assert (!busy)
    else
    begin
      $display("busy stayed high on the cycle after the result pulse");
      errors++;
      test_errors++;
    end
  endtask

  initial
  begin : main
    int    i;
    word_t op;
    word_t a;
    word_t b;
    word_t c;
    word_t d;
    word_t e;
    word_t f;
    word_t got;
    word_t op_result;

    void'($urandom(75));
    errors         = 0;
    test_errors    = 0;
    checks         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    reset          = 1'b1;
    start          = 1'b0;
    mode           = mode_sign;
    r13            = '0;
    r14            = '0;
    r15            = '0;
    pc             = '0;
    host_valid     = 1'b0;
    host_we        = 1'b0;
    host_addr      = '0;
    host_wdata     = '0;
    spm_load_valid = 1'b0;
    spm_load_slot  = '0;
    spm_load_field = field_pub_start;
    spm_load_data  = '0;
    $readmemh("verif/mac_golden.txt", gold);

    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    #1;
    assert (!busy && !result_valid && !host_ready && !host_rvalid)
    else
    begin
      $display("Outputs are not idle after reset");
      errors++;
    end

    i = 0;
    while (i + 6 < GOLD_WORDS && gold[i] !== 16'h000F)
    begin
      op = gold[i];
      a  = gold[i + 1];
      b  = gold[i + 2];
      c  = gold[i + 3];
      d  = gold[i + 4];
      e  = gold[i + 5];
      f  = gold[i + 6];
      case (op)
        16'h0000:
        begin
          tests_run++;
          if (test_errors == 0)
            $display("Test %0d passed", a);
          else
          begin
            $display("Test %0d failed with %0d errors", a, test_errors);
            tests_failed++;
          end
          test_errors = 0;
        end
        16'h0001:
        begin
          @(negedge clk);
          spm_load_valid = 1'b1;
          spm_load_slot  = a[SLOT_W-1:0];
          spm_load_field = spm_field_t'(b[2:0]);
          spm_load_data  = c;
          @(negedge clk);
          spm_load_valid = 1'b0;
        end
        16'h0002: host_access(1'b1, a, b, got);
        16'h0003:
        begin
          host_access(1'b0, a, '0, got);
          check_word($sformatf("host_rdata @%h", a), got, b);
        end
        16'h0004:
        begin
          fork
            run_operation(mac_mode_t'(a[0]), b, c, d, e, op_result);
            begin : background_reads
              word_t bg_got;
              int    w;
              w = 0;
              @(negedge clk);
              // Reads begin once the operation is running
              while (!busy)
              begin
                w++;
                if (w > WAIT_LIMIT)
                  abort_on_timeout("busy high for overlapped reads");
                @(negedge clk);
              end
              for (int k = 0; k < bg_addr.size(); k++)
              begin
                repeat ($urandom % 4) @(negedge clk);
                host_access(1'b0, bg_addr[k], '0, bg_got);
                check_word($sformatf("host_rdata @%h", bg_addr[k]), bg_got, bg_data[k]);
              end
            end
          join
          check_word("result", op_result, f);
          bg_addr.delete();
          bg_data.delete();
        end
        16'h0005:
        begin
          bg_addr.push_back(a);
          bg_data.push_back(b);
        end
        default:
        begin
          $display("Unknown golden record %h at word %0d", op, i);
          errors++;
          i = GOLD_WORDS;
        end
      endcase
      i += 7;
    end

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_run > 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic clk
);

  initial clk = 1'b0;

  // 4 ns period
  always #2 clk = ~clk;

endmodule

`default_nettype wire

//--- logic/mac_unit_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "mac_consts.svh"

module mac_unit_top (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          start,
  input  wire mac_pkg::mac_mode_t      mode,
  input  wire mem_pkg::addr_t          r13,
  input  wire mem_pkg::addr_t          r14,
  input  wire mem_pkg::addr_t          r15,
  input  wire mem_pkg::addr_t          pc,
  output wire                          busy,
  output wire mem_pkg::word_t          result,
  output wire                          result_valid,
  input  wire                          host_valid,
  output wire                          host_ready,
  input  wire                          host_we,
  input  wire mem_pkg::addr_t          host_addr,
  input  wire mem_pkg::word_t          host_wdata,
  output wire                          host_rvalid,
  output wire mem_pkg::word_t          host_rdata,
  input  wire                          spm_load_valid,
  input  wire [$clog2(`SPM_SLOTS)-1:0] spm_load_slot,
  input  wire mac_pkg::spm_field_t     spm_load_field,
  input  wire mem_pkg::word_t          spm_load_data
);

  mem_bus_if    host_bus ();
  mem_bus_if    ctrl_bus ();
  mem_bus_if    ram_bus ();
  spm_query_if  query ();
  mac_engine_if mac ();

  // Host port onto its bus
  assign host_bus.req_valid = host_valid;
  assign host_bus.we        = host_we;
  assign host_bus.addr      = host_addr;
  assign host_bus.wdata     = host_wdata;
  assign host_ready         = host_bus.req_ready;
  assign host_rvalid        = host_bus.rsp_valid;
  assign host_rdata         = host_bus.rdata;

  mac_control u_control (
    .clk(clk), .reset(reset), .start(start), .mode(mode),
    .r13(r13), .r14(r14), .r15(r15), .pc(pc),
    .busy(busy), .result(result), .result_valid(result_valid),
    .mem(ctrl_bus), .query(query), .mac(mac)
  );

  mac_engine u_engine (.clk(clk), .reset(reset), .mac(mac));

  spm_table u_table (
    .clk(clk), .reset(reset), .load_valid(spm_load_valid), .load_slot(spm_load_slot),
    .load_field(spm_load_field), .load_data(spm_load_data), .query(query)
  );

  mem_arbiter u_arbiter (
    .clk(clk), .reset(reset), .host(host_bus), .ctrl(ctrl_bus), .mem(ram_bus)
  );

  data_ram u_ram (.clk(clk), .mem(ram_bus));

endmodule

`default_nettype wire

//--- logic/mac_control.sv
`timescale 1ns/1ns
`default_nettype none

module mac_control (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     start,
  input  wire mac_pkg::mac_mode_t mode,
  input  wire mem_pkg::addr_t     r13,
  input  wire mem_pkg::addr_t     r14,
  input  wire mem_pkg::addr_t     r15,
  input  wire mem_pkg::addr_t     pc,
  output logic                    busy,
  output mem_pkg::word_t          result,
  output logic                    result_valid,
  mem_bus_if.master               mem,
  spm_query_if.master             query,
  mac_engine_if.ctrl              mac
);
  import mem_pkg::*;
  import mac_pkg::*;

  ctrl_state_t state;
  ctrl_state_t next_state;
  mac_mode_t   mode_q;
  logic [1:0]  field_idx;
  addr_t       cur;
  addr_t       limit;
  word_t       data_q;
  word_t       result_q;
  logic        range_done;
  logic        is_sign;

  // Memory is little endian
  function automatic word_t swap_bytes(word_t w);
    return {w[7:0], w[15:8]};
  endfunction

  assign is_sign    = (mode_q == mode_sign);
  assign range_done = (cur >= limit);

  assign busy         = (state != st_idle);
  assign result_valid = (state == st_done);
  assign result       = result_q;

  assign query.select = is_sign ? pc : r14;

  always_comb
  begin
    case (state)
      st_setup:   query.field = field_pub_start;
      st_limit:   query.field = field_pub_end;
      st_field:   query.field = spm_field_t'({1'b0, field_idx});
      st_tag_rsp: query.field = field_id;
      default:    query.field = field_pub_start;
    endcase
  end

  assign mem.req_valid = (state == st_mem_req && !range_done) || (state == st_tag_req);
  assign mem.we        = (state == st_tag_req) && is_sign;
  assign mem.addr      = (state == st_tag_req) ? r15 : cur;
  assign mem.wdata     = mac.tag;

  assign mac.clear        = (state == st_idle);
  assign mac.absorb_valid = (state == st_absorb) || (state == st_field);
  assign mac.word         = (state == st_field) ? query.data : data_q;

  always_comb
  begin
    next_state = state;
    case (state)
      st_idle:     if (start) next_state = st_check;
      st_check:    next_state = query.select_valid ? st_setup : st_fail;
      st_fail:     next_state = st_done;
      st_setup:    next_state = st_limit;
      st_limit:    next_state = st_mem_req;
      st_mem_req:
        if (range_done)
          next_state = st_field;
        else if (mem.req_ready)
          next_state = st_mem_rsp;
      st_mem_rsp:  if (mem.rsp_valid) next_state = st_absorb;
      st_absorb:   if (mac.absorb_ready) next_state = st_mem_req;
      st_field:    if (mac.absorb_ready && field_idx == 2'd3) next_state = st_tag_wait;
      // Last absorb must finish before the tag is final
      st_tag_wait: if (mac.absorb_ready) next_state = st_tag_req;
      st_tag_req:  if (mem.req_ready) next_state = is_sign ? st_done : st_tag_rsp;
      st_tag_rsp:  if (mem.rsp_valid) next_state = st_done;
      st_done:     next_state = st_idle;
      default:     next_state = st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state     <= st_idle;
      mode_q    <= mode_sign;
      field_idx <= '0;
    end
    else
    begin
      state <= next_state;
      if (state == st_idle)
      begin
        mode_q    <= mode;
        field_idx <= '0;
      end
      else if (state == st_field && mac.absorb_ready)
        field_idx <= field_idx + 2'd1;
    end
  end

  // Address range, fetched word and result
  always_ff @(posedge clk)
  begin
    case (state)
      st_setup:  cur <= is_sign ? r13 : query.data;
      st_limit:  limit <= is_sign ? r14 : query.data;
      st_mem_rsp:
        if (mem.rsp_valid)
          data_q <= swap_bytes(mem.rdata);
      st_absorb:
        if (mac.absorb_ready)
          cur <= cur + 16'd2;
      st_fail:   result_q <= '0;
      st_tag_req:
        if (mem.req_ready && is_sign)
          result_q <= mac.tag;
      st_tag_rsp:
        if (mem.rsp_valid)
          result_q <= (swap_bytes(mem.rdata) == mac.tag) ? query.data : '0;
      default:   ;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/mac_engine.sv
`timescale 1ns/1ns
`default_nettype none

`include "mac_consts.svh"

module mac_engine (
  input wire           clk,
  input wire           reset,
  mac_engine_if.engine mac
);
  import mem_pkg::*;
  import mac_pkg::*;

  localparam int CNT_W = $clog2(`MAC_LATENCY + 1);

  tag_t             acc;
  word_t            held;
  logic [CNT_W-1:0] count;

  assign mac.absorb_ready = (count == '0);
  assign mac.tag          = acc ^ `MAC_KEY;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      acc   <= `MAC_KEY;
      count <= '0;
    end
    else if (mac.clear)
    begin
      acc   <= `MAC_KEY;
      count <= '0;
    end
    else if (mac.absorb_valid && mac.absorb_ready)
      count <= CNT_W'(`MAC_LATENCY);
    else if (count != '0)
    begin
      count <= count - 1'b1;
      // Rotate left by 3, xor, add round constant
      if (count == CNT_W'(1))
        acc <= ({acc[12:0], acc[15:13]} ^ held) + `MAC_ROUND;
    end
  end

  always_ff @(posedge clk)
  begin
    if (mac.absorb_valid && mac.absorb_ready)
      held <= mac.word;
  end

endmodule

`default_nettype wire

//--- logic/spm_table.sv
`timescale 1ns/1ns
`default_nettype none

`include "mac_consts.svh"

module spm_table (
  input wire                          clk,
  input wire                          reset,
  input wire                          load_valid,
  input wire [$clog2(`SPM_SLOTS)-1:0] load_slot,
  input wire mac_pkg::spm_field_t     load_field,
  input wire mem_pkg::word_t          load_data,
  spm_query_if.slave                  query
);
  import mem_pkg::*;
  import mac_pkg::*;

  localparam int SLOT_W      = $clog2(`SPM_SLOTS);
  localparam int FIELD_COUNT = 5;

  word_t                entry [`SPM_SLOTS][FIELD_COUNT];
  logic [`SPM_SLOTS-1:0] used;
  logic                 hit;
  logic [SLOT_W-1:0]    hit_slot;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      used <= '0;
      for (int s = 0; s < `SPM_SLOTS; s++)
        for (int f = 0; f < FIELD_COUNT; f++)
          entry[s][f] <= '0;
    end
    else if (load_valid)
    begin
      entry[load_slot][load_field] <= load_data;
      used[load_slot] <= 1'b1;
    end
  end

  // Walk down so the lowest matching slot wins
  always_comb
  begin
    hit      = 1'b0;
    hit_slot = '0;
    for (int s = `SPM_SLOTS - 1; s >= 0; s--)
    begin
      if (used[s] && entry[s][field_pub_start] <= query.select &&
          entry[s][field_pub_end] > query.select)
      begin
        hit      = 1'b1;
        hit_slot = SLOT_W'(s);
      end
    end
  end

  assign query.select_valid = hit;
  assign query.data         = entry[hit_slot][query.field];

endmodule

`default_nettype wire

//--- logic/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
  input wire        clk,
  input wire        reset,
  mem_bus_if.slave  host,
  mem_bus_if.slave  ctrl,
  mem_bus_if.master mem
);

  logic grant_ctrl;
  logic rd_pending;
  logic rd_ctrl;

  // Controller wins whenever it asks
  assign grant_ctrl = ctrl.req_valid;

  assign mem.req_valid = ctrl.req_valid || host.req_valid;
  assign mem.we        = grant_ctrl ? ctrl.we : host.we;
  assign mem.addr      = grant_ctrl ? ctrl.addr : host.addr;
  assign mem.wdata     = grant_ctrl ? ctrl.wdata : host.wdata;

  assign ctrl.req_ready = ctrl.req_valid && mem.req_ready;
  assign host.req_ready = host.req_valid && !ctrl.req_valid && mem.req_ready;

  // Owner of the read in flight
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      rd_pending <= 1'b0;
      rd_ctrl    <= 1'b0;
    end
    else
    begin
      rd_pending <= mem.req_valid && mem.req_ready && !mem.we;
      if (mem.req_valid && mem.req_ready)
        rd_ctrl <= grant_ctrl;
    end
  end

  assign ctrl.rsp_valid = mem.rsp_valid && rd_pending && rd_ctrl;
  assign host.rsp_valid = mem.rsp_valid && rd_pending && !rd_ctrl;
  assign ctrl.rdata     = mem.rdata;
  assign host.rdata     = mem.rdata;

endmodule

`default_nettype wire

//--- logic/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "mac_consts.svh"

module data_ram (
  input wire       clk,
  mem_bus_if.slave mem
);
  import mem_pkg::*;

  localparam int AW = $clog2(`MEM_WORDS);

  word_t         ram [`MEM_WORDS];
  logic [AW-1:0] index;

  // Word index from the byte address
  assign index = mem.addr[AW:1];

  assign mem.req_ready = 1'b1;

  always_ff @(posedge clk)
  begin
    if (mem.req_valid && mem.we)
      ram[index] <= mem.wdata;
    if (mem.req_valid && !mem.we)
      mem.rdata <= ram[index];
    mem.rsp_valid <= mem.req_valid && !mem.we;
  end

endmodule

`default_nettype wire

//--- logic/bus_ifs.sv
`timescale 1ns/1ns
`default_nettype none

interface mem_bus_if;
  import mem_pkg::*;

  logic  req_valid;
  logic  req_ready;
  logic  we;
  addr_t addr;
  word_t wdata;
  logic  rsp_valid;
  word_t rdata;

  modport master (output req_valid, we, addr, wdata, input req_ready, rsp_valid, rdata);
  modport slave (input req_valid, we, addr, wdata, output req_ready, rsp_valid, rdata);
endinterface

// Combinational lookup into the module table
interface spm_query_if;
  import mem_pkg::*;
  import mac_pkg::*;

  addr_t      select;
  logic       select_valid;
  spm_field_t field;
  word_t      data;

  modport master (output select, field, input select_valid, data);
  modport slave (input select, field, output select_valid, data);
endinterface

interface mac_engine_if;
  import mem_pkg::*;
  import mac_pkg::*;

  logic  clear;
  logic  absorb_valid;
  logic  absorb_ready;
  word_t word;
  tag_t  tag;

  modport ctrl (output clear, absorb_valid, word, input absorb_ready, tag);
  modport engine (input clear, absorb_valid, word, output absorb_ready, tag);
endinterface

`default_nettype wire

//--- logic/mac_pkg.sv
`default_nettype none

package mac_pkg;

  typedef enum logic {mode_sign, mode_verify} mac_mode_t;

  // Order of the first four matches the absorb order
  typedef enum logic [2:0] {
    field_pub_start, field_pub_end, field_sec_start, field_sec_end, field_id
  } spm_field_t;

  typedef logic [15:0] tag_t;

  typedef enum logic [3:0] {
    st_idle,
    st_check,
    st_fail,
    st_setup,
    st_limit,
    st_mem_req,
    st_mem_rsp,
    st_absorb,
    st_field,
    st_tag_wait,
    st_tag_req,
    st_tag_rsp,
    st_done
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

  typedef logic [15:0] word_t;

  // Byte address, memory index is bits 8:1
  typedef logic [15:0] addr_t;

endpackage

`default_nettype wire

//--- logic/mac_consts.svh
`ifndef MAC_CONSTS_SVH
`define MAC_CONSTS_SVH

// Secret key, also the accumulator seed
`define MAC_KEY 16'h5A3C

// Added once per mixing round
`define MAC_ROUND 16'h9E37

// Engine busy cycles per absorbed word
`define MAC_LATENCY 3

`define MEM_WORDS 256
`define SPM_SLOTS 4

`endif
